// ==== filelist.f ====
rtl/udp_proto_pkg.sv
rtl/udp_tx_pkg.sv
rtl/tx_frame_if.sv
rtl/tx_sync_fifo.sv
rtl/tx_frame_queue.sv
rtl/arp_cache.sv
rtl/ip_header_calc.sv
rtl/udp_tx_framer.sv
rtl/udp_tx.sv
test/udp_tx_tb.sv

// ==== Bender.yml ====
package:
  name: udp_tx

sources:
  - rtl/udp_proto_pkg.sv
  - rtl/udp_tx_pkg.sv
  - rtl/tx_frame_if.sv
  - rtl/tx_sync_fifo.sv
  - rtl/tx_frame_queue.sv
  - rtl/arp_cache.sv
  - rtl/ip_header_calc.sv
  - rtl/udp_tx_framer.sv
  - rtl/udp_tx.sv
  - target: test
    files:
      - test/udp_tx_tb.sv

// ==== test/udp_tx_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module udp_tx_tb;
  import udp_proto_pkg::*;
  import udp_tx_pkg::*;

  localparam int clk_half = 20;     // 40 ns period
  localparam int drive_delay = 2;
  localparam int max_words = 20;
  localparam int max_ack_delay = 4;
  localparam int num_frames = 16;   // Frames expected on the MAC side
  localparam int fill_words = 300;  // Words sent in the overflow test
  localparam int fill_frames = 3;   // Long frames keep the control FIFO low
  localparam int timeout_cycles =
    2 * (num_frames * (max_words + 6 + max_ack_delay + 24) + 2 * 256 + fill_words + 200);

  logic mac_clk;
  logic app_rst;
  logic local_enable;
  mac_addr_t local_mac;
  ip_addr_t local_ip;
  udp_port_t local_port;
  arp_addr_t local_gateway;
  ip_addr_t local_netmask;
  arp_addr_t arp_cache_addr;
  mac_addr_t arp_cache_rd_data;
  mac_addr_t arp_cache_wr_data;
  logic arp_cache_wr_en;
  logic app_tx_valid;
  logic app_tx_end_of_frame;
  word_t app_tx_data;
  ip_addr_t app_tx_dest_ip;
  udp_port_t app_tx_dest_port;
  logic app_tx_overflow;
  logic app_tx_afull;
  word_t mac_tx_data;
  byte_en_t mac_tx_data_valid;
  logic mac_tx_start;
  logic mac_tx_ack;

  logic [31:0] rng_state = 32'h1448;
  mac_addr_t arp_model [256];   // Own copy of the ARP table
  logic [7:0] exp_bytes [$];    // Expected wire bytes of all queued frames
  int exp_len [$];              // Words per queued frame
  int errors = 0;
  int words_checked = 0;
  int frames_checked = 0;
  logic in_frame = 1'b0;
  logic last_seen = 1'b0;
  int word_idx = 0;
  int cur_len = 0;

  udp_tx udp_tx_inst (.*);

  initial begin
    mac_clk = 1'b0;
    forever #clk_half mac_clk = ~mac_clk;
  end

  initial begin
    repeat (timeout_cycles) @(posedge mac_clk);
    $display("Timeout after %0d clock cycles with %0d frames still pending",
             timeout_cycles, exp_len.size());
    $display("Simulation failed");
    $finish;
  end

  function automatic logic [31:0] next_rand();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  function automatic word_t random_word();
    return {next_rand(), next_rand()};
  endfunction

  function automatic ip_addr_t random_dest(input int kind);
    logic [31:0] r;
    r = next_rand();
    case (kind)
      0: return {local_ip[31:8], r[23:16]};  // Same /24 subnet
      1: return {8'h0a, r[31:8]};            // Off subnet
      default: return {mcast_ip_nibble, r[31:4]};
    endcase
  endfunction

  function automatic mac_addr_t expected_dest_mac(input ip_addr_t ip);
    if (ip[31:28] == mcast_ip_nibble) return {mcast_mac_prefix, 1'b0, ip[22:0]};
    if ((ip & local_netmask) == (local_ip & local_netmask)) return arp_model[ip[7:0]];
    return arp_model[local_gateway];
  endfunction

  // Ones' complement sum of the ten header halfwords with the checksum field as zero
  function automatic len16_t header_checksum(input len16_t ip_len, input ip_addr_t dst);
    logic [31:0] sum;
    sum = 32'({ip_ver_ihl, 8'h00}) + 32'(ip_len) + 32'(ip_flags_dont_frag) +
          32'({ip_ttl, ip_proto_udp}) + 32'(local_ip[31:16]) + 32'(local_ip[15:0]) +
          32'(dst[31:16]) + 32'(dst[15:0]);
    while (sum[31:16] != 16'h0000) sum = 32'(sum[15:0]) + 32'(sum[31:16]);
    return ~sum[15:0];
  endfunction

  task automatic push_be(input word_t v, input int nbytes);
    for (int i = nbytes - 1; i >= 0; i--) exp_bytes.push_back(v[8*i +: 8]);
  endtask

  task automatic send_frame(input ip_addr_t ip, input udp_port_t port, input int n);
    word_t payload [$];
    len16_t ip_len;
    len16_t udp_len;
    ip_len = len16_t'(8 * n) + ip_udp_hdr_bytes;
    udp_len = len16_t'(8 * n) + udp_hdr_bytes;
    for (int i = 0; i < n; i++) payload.push_back(random_word());
    push_be(expected_dest_mac(ip), 6);
    push_be(local_mac, 6);
    push_be(ethertype_ipv4, 2);
    push_be({ip_ver_ihl, 8'h00}, 2);
    push_be(ip_len, 2);
    push_be(16'h0000, 2);            // ID
    push_be(ip_flags_dont_frag, 2);
    push_be({ip_ttl, ip_proto_udp}, 2);
    push_be(header_checksum(ip_len, ip), 2);
    push_be(local_ip, 4);
    push_be(ip, 4);
    push_be(local_port, 2);
    push_be(port, 2);
    push_be(udp_len, 2);
    push_be(16'h0000, 2);            // UDP checksum unused
    foreach (payload[i]) push_be(payload[i], 8);
    exp_len.push_back(n + 6);
    for (int i = 0; i < n; i++) begin
      @(posedge mac_clk);
      #drive_delay;
      app_tx_valid = 1'b1;
      app_tx_data = payload[i];
      app_tx_end_of_frame = (i == n - 1);
      app_tx_dest_ip = ip;
      app_tx_dest_port = port;
    end
    @(posedge mac_clk);
    #drive_delay;
    app_tx_valid = 1'b0;
    app_tx_end_of_frame = 1'b0;
  endtask

  task automatic fill_arp_table();
    word_t w;
    for (int i = 0; i < 256; i++) begin
      w = random_word();
      @(posedge mac_clk);
      #drive_delay;
      arp_cache_addr = arp_addr_t'(i);
      arp_cache_wr_data = w[47:0];
      arp_cache_wr_en = 1'b1;
      arp_model[i] = w[47:0];
    end
    @(posedge mac_clk);
    #drive_delay arp_cache_wr_en = 1'b0;
  endtask

  task automatic check_arp_entry(input arp_addr_t addr);
    @(posedge mac_clk);
    #drive_delay arp_cache_addr = addr;
    @(posedge mac_clk);
    @(negedge mac_clk);
    assert (arp_cache_rd_data == arp_model[addr]) else begin
      errors++;
      $display("error at %0t ns: ARP entry %h reads %h, expected %h",
               $time, addr, arp_cache_rd_data, arp_model[addr]);
    end
  endtask

  task automatic drain_frames();
    while (exp_len.size() != 0 || in_frame) @(posedge mac_clk);
    repeat (2) @(posedge mac_clk);
  endtask

  task automatic apply_reset();
    @(posedge mac_clk);
    #drive_delay app_rst = 1'b1;
    repeat (2) @(posedge mac_clk);
    #drive_delay app_rst = 1'b0;
    exp_bytes.delete();
    exp_len.delete();
  endtask

  // MAC model that acks the first word after a random wait
  initial begin
    int delay;
    mac_tx_ack = 1'b0;
    forever begin
      @(negedge mac_clk);
      if (mac_tx_start) begin
        delay = int'(next_rand() % (max_ack_delay + 1));
        repeat (delay + 1) @(posedge mac_clk);
        #drive_delay mac_tx_ack = 1'b1;
        @(posedge mac_clk);
        #drive_delay mac_tx_ack = 1'b0;
      end
    end
  end

  // Mid-cycle compare of every transferred word
  always @(negedge mac_clk) begin : monitor
    word_t exp_word;
    word_t lane_bits;
    byte_en_t exp_mask;
    if (app_rst) begin
      in_frame = 1'b0;
      last_seen = 1'b0;
    end else begin
      if (last_seen) begin
        assert (mac_tx_data_valid == '0 && !mac_tx_start) else begin
          errors++;
          $display("error at %0t ns: output not idle after the last word", $time);
        end
      end
      last_seen = 1'b0;
      if (!in_frame && mac_tx_ack) begin
        if (exp_len.size() == 0) begin
          errors++;
          $display("A frame was acknowledged at %0t ns although none was queued", $time);
        end else begin
          cur_len = exp_len.pop_front();
          word_idx = 0;
          in_frame = 1'b1;
        end
      end
      if (in_frame) begin
        exp_mask = (word_idx == cur_len - 1) ? byte_en_last : 8'hff;
        exp_word = '0;
        lane_bits = '0;
        for (int i = 0; i < 8; i++) begin
          if (exp_mask[i]) begin
            exp_word[8*i +: 8] = exp_bytes.pop_front();
            lane_bits[8*i +: 8] = 8'hff;
          end
        end
        assert (mac_tx_data_valid == exp_mask && ((mac_tx_data ^ exp_word) & lane_bits) == '0)
        else begin
          errors++;
          $display("error at %0t ns: word %0d is %h/%h, expected %h/%h", $time, word_idx,
                   mac_tx_data, mac_tx_data_valid, exp_word, exp_mask);
        end
        words_checked++;
        word_idx++;
        if (word_idx == cur_len) begin
          in_frame = 1'b0;
          last_seen = 1'b1;
          frames_checked++;
        end
      end
    end
  end

  no_start_disabled: assert property (@(posedge mac_clk) disable iff (app_rst)
    !local_enable |-> !mac_tx_start)
  else begin
    errors++;
    $display("error at %0t ns: mac_tx_start while local_enable is low", $time);
  end

  no_start_overflow: assert property (@(posedge mac_clk) disable iff (app_rst)
    app_tx_overflow |-> !mac_tx_start)
  else begin
    errors++;
    $display("error at %0t ns: mac_tx_start after overflow", $time);
  end

  afull_first: assert property (@(posedge mac_clk) disable iff (app_rst)
    $rose(app_tx_overflow) |-> $past(app_tx_afull))
  else begin
    errors++;
    $display("error at %0t ns: overflow without a prior almost-full", $time);
  end

  start_word_valid: assert property (@(posedge mac_clk) disable iff (app_rst)
    mac_tx_start |-> mac_tx_data_valid == 8'hff)
  else begin
    errors++;
    $display("error at %0t ns: first word not fully valid at start", $time);
  end

  initial begin
    app_rst = 1'b1;
    local_enable = 1'b0;
    local_mac = 48'h02_11_22_33_44_55;
    local_ip = 32'hc0a8_010a;       // 192.168.1.10
    local_port = 16'd5000;
    local_gateway = 8'h01;
    local_netmask = 32'hffff_ff00;
    arp_cache_addr = '0;
    arp_cache_wr_data = '0;
    arp_cache_wr_en = 1'b0;
    app_tx_valid = 1'b0;
    app_tx_end_of_frame = 1'b0;
    app_tx_data = '0;
    app_tx_dest_ip = '0;
    app_tx_dest_port = '0;
    repeat (2) @(posedge mac_clk);
    #drive_delay app_rst = 1'b0;

    fill_arp_table();
    for (int i = 0; i < 8; i++) check_arp_entry(arp_addr_t'(next_rand() >> 24));
    check_arp_entry(local_gateway);

    // Unicast, gateway and multicast frames in turn
    @(posedge mac_clk);
    #drive_delay local_enable = 1'b1;
    for (int i = 0; i < 12; i++) begin
      send_frame(random_dest(i % 3), udp_port_t'(next_rand() >> 16),
                 (i == 0) ? 1 : (i == 1) ? max_words : int'(next_rand() % max_words) + 1);
    end
    drain_frames();

    // Frames wait while disabled
    @(posedge mac_clk);
    #drive_delay local_enable = 1'b0;
    for (int i = 0; i < 3; i++) send_frame(random_dest(i), 16'd7000 + 16'(i), 3 + i);
    repeat (30) @(posedge mac_clk);
    #drive_delay local_enable = 1'b1;
    drain_frames();

    // Fill the data FIFO past full
    @(posedge mac_clk);
    #drive_delay local_enable = 1'b0;
    for (int i = 0; i < fill_frames; i++) begin
      send_frame(random_dest(0), 16'd9, fill_words / fill_frames);
    end
    assert (app_tx_overflow) else begin
      errors++;
      $display("The overflow flag did not rise after the data FIFO was overfilled");
    end
    @(posedge mac_clk);
    #drive_delay local_enable = 1'b1;
    repeat (40) @(posedge mac_clk);
    apply_reset();
    assert (!app_tx_overflow) else begin
      errors++;
      $display("The overflow flag stayed set through reset");
    end
    send_frame(random_dest(1), 16'd1234, 5);
    drain_frames();

    $display("Checked %0d frames and %0d words, %0d errors", frames_checked, words_checked,
             errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== rtl/udp_tx.sv ====
`timescale 1ns/10ps
`default_nettype none

module udp_tx (
  input logic mac_clk,
  input logic app_rst,
  // Local settings
  input logic local_enable,
  input udp_tx_pkg::mac_addr_t local_mac,
  input udp_tx_pkg::ip_addr_t local_ip,
  input udp_tx_pkg::udp_port_t local_port,
  input udp_tx_pkg::arp_addr_t local_gateway,
  input udp_tx_pkg::ip_addr_t local_netmask,
  // ARP table access
  input udp_tx_pkg::arp_addr_t arp_cache_addr,
  output udp_tx_pkg::mac_addr_t arp_cache_rd_data,
  input udp_tx_pkg::mac_addr_t arp_cache_wr_data,
  input logic arp_cache_wr_en,
  // Application
  input logic app_tx_valid,
  input logic app_tx_end_of_frame,
  input udp_tx_pkg::word_t app_tx_data,
  input udp_tx_pkg::ip_addr_t app_tx_dest_ip,
  input udp_tx_pkg::udp_port_t app_tx_dest_port,
  output logic app_tx_overflow,
  output logic app_tx_afull,
  // MAC
  output udp_tx_pkg::word_t mac_tx_data,
  output udp_tx_pkg::byte_en_t mac_tx_data_valid,
  output logic mac_tx_start,
  input logic mac_tx_ack
);
  import udp_tx_pkg::*;

  mac_addr_t dest_mac;
  len16_t ip_length;
  len16_t udp_length;
  len16_t ip_checksum;

  tx_frame_if frame_bus ();

  tx_frame_queue queue_inst (
    .mac_clk(mac_clk),
    .app_rst(app_rst),
    .app_tx_valid(app_tx_valid),
    .app_tx_end_of_frame(app_tx_end_of_frame),
    .app_tx_data(app_tx_data),
    .app_tx_dest_ip(app_tx_dest_ip),
    .app_tx_dest_port(app_tx_dest_port),
    .app_tx_afull(app_tx_afull),
    .app_tx_overflow(app_tx_overflow),
    .frame(frame_bus)
  );

  arp_cache arp_inst (
    .mac_clk(mac_clk),
    .local_ip(local_ip),
    .local_netmask(local_netmask),
    .local_gateway(local_gateway),
    .frame(frame_bus),
    .arp_cache_addr(arp_cache_addr),
    .arp_cache_wr_data(arp_cache_wr_data),
    .arp_cache_wr_en(arp_cache_wr_en),
    .arp_cache_rd_data(arp_cache_rd_data),
    .dest_mac(dest_mac)
  );

  ip_header_calc calc_inst (
    .mac_clk(mac_clk),
    .app_rst(app_rst),
    .local_ip(local_ip),
    .frame(frame_bus),
    .ip_length(ip_length),
    .udp_length(udp_length),
    .ip_checksum(ip_checksum)
  );

  udp_tx_framer framer_inst (
    .mac_clk(mac_clk),
    .app_rst(app_rst),
    .local_enable(local_enable),
    .local_mac(local_mac),
    .local_ip(local_ip),
    .local_port(local_port),
    .dest_mac(dest_mac),
    .ip_length(ip_length),
    .udp_length(udp_length),
    .ip_checksum(ip_checksum),
    .frame(frame_bus),
    .mac_tx_data(mac_tx_data),
    .mac_tx_data_valid(mac_tx_data_valid),
    .mac_tx_start(mac_tx_start),
    .mac_tx_ack(mac_tx_ack)
  );

endmodule

`default_nettype wire

// ==== rtl/udp_tx_framer.sv ====
`timescale 1ns/10ps
`default_nettype none

module udp_tx_framer (
  input logic mac_clk,
  input logic app_rst,
  input logic local_enable,
  input udp_tx_pkg::mac_addr_t local_mac,
  input udp_tx_pkg::ip_addr_t local_ip,
  input udp_tx_pkg::udp_port_t local_port,
  input udp_tx_pkg::mac_addr_t dest_mac,
  input udp_tx_pkg::len16_t ip_length,
  input udp_tx_pkg::len16_t udp_length,
  input udp_tx_pkg::len16_t ip_checksum,
  tx_frame_if.framer frame,
  output udp_tx_pkg::word_t mac_tx_data,
  output udp_tx_pkg::byte_en_t mac_tx_data_valid,
  output logic mac_tx_start,
  input logic mac_tx_ack
);
  import udp_proto_pkg::*;
  import udp_tx_pkg::*;

  tx_state_e state;
  word_count_t rem_words; // Payload words still to pop
  logic gap;
  logic go;
  logic is_mcast;
  logic [15:0] leftover;  // Tail of the previous payload word
  word_t eth_ucast_w;
  word_t eth_mcast_w;
  word_t eth_type_w;
  word_t ip_len_w;
  word_t ip_addr_w;
  word_t udp_w;
  word_t data_first_w;
  word_t data_w;
  word_t data_last_w;

  // Big-endian field order to MAC lanes with lane 0 first on the wire
  function automatic word_t to_lanes(input word_t be);
    word_t le;
    for (int i = 0; i < 8; i++) begin
      le[8*i +: 8] = be[8*(7-i) +: 8];
    end
    return le;
  endfunction

  assign is_mcast = (frame.dest_ip[31:28] == mcast_ip_nibble);
  assign go = frame.frame_ready && local_enable && !gap; // One idle cycle between frames
  assign mac_tx_start = (state == idle) && go;

  assign eth_ucast_w = to_lanes({dest_mac, local_mac[47:32]});
  assign eth_mcast_w = to_lanes({mcast_mac_prefix, 1'b0, frame.dest_ip[22:0],
                                 local_mac[47:32]});
  assign eth_type_w = to_lanes({local_mac[31:0], ethertype_ipv4, ip_ver_ihl, 8'h00});
  assign ip_len_w = to_lanes({ip_length, 16'h0000, ip_flags_dont_frag, ip_ttl,
                              ip_proto_udp});
  assign ip_addr_w = to_lanes({ip_checksum, local_ip, frame.dest_ip[31:16]});
  assign udp_w = to_lanes({frame.dest_ip[15:0], local_port, frame.dest_port, udp_length});
  assign data_first_w = to_lanes({16'h0000, frame.word[63:16]}); // No UDP checksum
  assign data_w = to_lanes({leftover, frame.word[63:16]});
  assign data_last_w = to_lanes({leftover, 48'h0});

  always_comb begin
    mac_tx_data = '0;
    mac_tx_data_valid = '1;
    case (state)
      idle: begin
        mac_tx_data = is_mcast ? eth_mcast_w : eth_ucast_w;
        mac_tx_data_valid = go ? '1 : '0;
      end
      hdr_eth_ucast: mac_tx_data = eth_ucast_w;
      hdr_eth_mcast: mac_tx_data = eth_mcast_w;
      hdr_eth_type: mac_tx_data = eth_type_w;
      hdr_ip_len: mac_tx_data = ip_len_w;
      hdr_ip_addr: mac_tx_data = ip_addr_w;
      hdr_udp: mac_tx_data = udp_w;
      data_first: mac_tx_data = data_first_w;
      data: mac_tx_data = data_w;
      data_last: begin
        mac_tx_data = data_last_w;
        mac_tx_data_valid = byte_en_last;
      end
      default: mac_tx_data_valid = '0;
    endcase
  end

  // First payload word is popped one cycle ahead of data_first
  assign frame.word_rd = (state == hdr_udp) ||
                         ((state == data_first || state == data) && rem_words != '0);
  assign frame.frame_done = (state == data_last);

  always_ff @(posedge mac_clk) begin
    if (app_rst) begin
      state <= idle;
      rem_words <= '0;
      gap <= 1'b0;
    end else begin
      gap <= (state == data_last);
      case (state)
        idle: begin
          if (go) begin
            rem_words <= frame.word_count - 1'b1;
            state <= is_mcast ? hdr_eth_mcast : hdr_eth_ucast;
          end
        end
        hdr_eth_ucast, hdr_eth_mcast: begin
          if (mac_tx_ack) state <= hdr_eth_type; // MAC back-pressure
        end
        hdr_eth_type: state <= hdr_ip_len;
        hdr_ip_len: state <= hdr_ip_addr;
        hdr_ip_addr: state <= hdr_udp;
        hdr_udp: state <= data_first;
        data_first, data: begin
          if (rem_words == '0) begin
            state <= data_last;
          end else begin
            rem_words <= rem_words - 1'b1;
            state <= data;
          end
        end
        data_last: state <= idle;
        default: state <= idle;
      endcase
    end
  end

  always_ff @(posedge mac_clk) begin
    if (state == data_first || state == data) leftover <= frame.word[15:0];
  end

  a_last_mask: assert property (@(posedge mac_clk) disable iff (app_rst)
    (mac_tx_data_valid == byte_en_last) |-> (state == data_last));

  a_no_pop_idle: assert property (@(posedge mac_clk) disable iff (app_rst)
    (state == idle) |-> !frame.word_rd);

endmodule

`default_nettype wire

// ==== rtl/ip_header_calc.sv ====
`timescale 1ns/10ps
`default_nettype none

module ip_header_calc (
  input logic mac_clk,
  input logic app_rst,
  input udp_tx_pkg::ip_addr_t local_ip,
  tx_frame_if.calc frame,
  output udp_tx_pkg::len16_t ip_length,
  output udp_tx_pkg::len16_t udp_length,
  output udp_tx_pkg::len16_t ip_checksum
);
  import udp_proto_pkg::*;
  import udp_tx_pkg::*;

  typedef logic [19:0] csum_t; // Room for nine 16-bit terms

  len16_t payload_bytes;
  ip_addr_t dest_ip_q;
  csum_t sum_q;
  logic [16:0] fold1;
  len16_t fold2;

  assign payload_bytes = {frame.word_count[12:0], 3'b000};

  assign fold1 = {1'b0, sum_q[15:0]} + {13'b0, sum_q[19:16]};
  assign fold2 = fold1[15:0] + {15'b0, fold1[16]};

  always_ff @(posedge mac_clk) begin
    if (app_rst) begin
      ip_length <= '0;
      udp_length <= '0;
      dest_ip_q <= '0;
      sum_q <= '0;
      ip_checksum <= '0;
    end else begin
      // Stage 1, lengths
      ip_length <= payload_bytes + ip_udp_hdr_bytes;
      udp_length <= payload_bytes + udp_hdr_bytes;
      dest_ip_q <= frame.dest_ip; // Keeps address in step with length
      // Stage 2, raw sum of the header
      sum_q <= csum_t'({ip_ver_ihl, 8'h00}) +
               csum_t'(ip_length) +
               csum_t'(16'h0000) +            // ID
               csum_t'(ip_flags_dont_frag) +
               csum_t'({ip_ttl, ip_proto_udp}) +
               csum_t'(local_ip[31:16]) +
               csum_t'(local_ip[15:0]) +
               csum_t'(dest_ip_q[31:16]) +
               csum_t'(dest_ip_q[15:0]);
      // Stage 3, end-around carry and invert
      ip_checksum <= ~fold2;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/arp_cache.sv ====
`timescale 1ns/10ps
`default_nettype none

module arp_cache (
  input logic mac_clk,
  input udp_tx_pkg::ip_addr_t local_ip,
  input udp_tx_pkg::ip_addr_t local_netmask,
  input udp_tx_pkg::arp_addr_t local_gateway,
  tx_frame_if.calc frame,
  input udp_tx_pkg::arp_addr_t arp_cache_addr,
  input udp_tx_pkg::mac_addr_t arp_cache_wr_data,
  input logic arp_cache_wr_en,
  output udp_tx_pkg::mac_addr_t arp_cache_rd_data,
  output udp_tx_pkg::mac_addr_t dest_mac
);
  import udp_tx_pkg::*;

  localparam int entries = 2 ** $bits(arp_addr_t);

  mac_addr_t mac_table [entries];
  arp_addr_t next_hop;

  // Same subnet goes direct, anything else via the gateway
  assign next_hop = ((frame.dest_ip & local_netmask) == (local_ip & local_netmask))
                    ? frame.dest_ip[7:0] : local_gateway;

  // Write and read-back port
  always_ff @(posedge mac_clk) begin
    if (arp_cache_wr_en) mac_table[arp_cache_addr] <= arp_cache_wr_data;
    arp_cache_rd_data <= mac_table[arp_cache_addr];
  end

  // Lookup port
  always_ff @(posedge mac_clk) begin
    dest_mac <= mac_table[next_hop];
  end

endmodule

`default_nettype wire

// ==== rtl/tx_frame_queue.sv ====
`timescale 1ns/10ps
`default_nettype none

module tx_frame_queue (
  input logic mac_clk,
  input logic app_rst,
  input logic app_tx_valid,
  input logic app_tx_end_of_frame,
  input udp_tx_pkg::word_t app_tx_data,
  input udp_tx_pkg::ip_addr_t app_tx_dest_ip,
  input udp_tx_pkg::udp_port_t app_tx_dest_port,
  output logic app_tx_afull,
  output logic app_tx_overflow,
  tx_frame_if.queue frame
);
  import udp_tx_pkg::*;

  localparam int ctrl_w = $bits(word_count_t) + $bits(udp_port_t) + $bits(ip_addr_t);

  logic in_valid;
  logic in_eof;
  word_t in_data;
  ip_addr_t in_ip;
  udp_port_t in_port;
  word_count_t word_cnt; // Words before the current one
  logic data_afull;
  logic data_full;
  logic data_empty;
  logic ctrl_afull;
  logic ctrl_full;
  logic ctrl_empty;
  logic [ctrl_w-1:0] ctrl_rd_data;
  logic overflow;

  always_ff @(posedge mac_clk) begin
    in_data <= app_tx_data;
    if (app_tx_valid && app_tx_end_of_frame) begin
      in_ip <= app_tx_dest_ip;
      in_port <= app_tx_dest_port;
    end
  end

  always_ff @(posedge mac_clk) begin
    if (app_rst) begin
      in_valid <= 1'b0;
      in_eof <= 1'b0;
      word_cnt <= '0;
      overflow <= 1'b0;
    end else begin
      in_valid <= app_tx_valid;
      in_eof <= app_tx_valid && app_tx_end_of_frame;
      if (in_valid) word_cnt <= in_eof ? '0 : word_cnt + 1'b1;
      // Sticky until reset
      if ((in_valid && data_full) || (in_valid && in_eof && ctrl_full)) overflow <= 1'b1;
    end
  end

  tx_sync_fifo #(
    .width($bits(word_t)),
    .depth(data_fifo_depth),
    .first_word_fall_through(1'b0)
  ) data_fifo (
    .mac_clk(mac_clk),
    .app_rst(app_rst),
    .wr_en(in_valid),
    .wr_data(in_data),
    .rd_en(frame.word_rd),
    .rd_data(frame.word),
    .empty(data_empty),
    .afull(data_afull),
    .full(data_full)
  );

  // Count includes the end-of-frame word itself
  tx_sync_fifo #(
    .width(ctrl_w),
    .depth(ctrl_fifo_depth),
    .first_word_fall_through(1'b1)
  ) ctrl_fifo (
    .mac_clk(mac_clk),
    .app_rst(app_rst),
    .wr_en(in_valid && in_eof),
    .wr_data({word_cnt + 1'b1, in_port, in_ip}),
    .rd_en(frame.frame_done),
    .rd_data(ctrl_rd_data),
    .empty(ctrl_empty),
    .afull(ctrl_afull),
    .full(ctrl_full)
  );

  assign {frame.word_count, frame.dest_port, frame.dest_ip} = ctrl_rd_data;
  assign frame.frame_ready = !ctrl_empty && !overflow;

  assign app_tx_afull = data_afull || ctrl_afull;
  assign app_tx_overflow = overflow;

  // A ready frame has all its words queued until its last word goes out
  a_words_queued: assert property (@(posedge mac_clk) disable iff (app_rst)
    frame.frame_ready && !frame.frame_done |-> !data_empty || $past(frame.word_rd));

endmodule

`default_nettype wire

// ==== rtl/tx_sync_fifo.sv ====
`timescale 1ns/10ps
`default_nettype none

module tx_sync_fifo #(
  parameter int width = 64,
  parameter int depth = 16,
  parameter bit first_word_fall_through = 1'b0
) (
  input logic mac_clk,
  input logic app_rst,
  input logic wr_en,
  input logic [width-1:0] wr_data,
  input logic rd_en,
  output logic [width-1:0] rd_data,
  output logic empty,
  output logic afull,
  output logic full
);
  import udp_tx_pkg::*;

  localparam int aw = $clog2(depth);

  logic [width-1:0] mem [depth];
  logic [aw-1:0] wr_ptr;
  logic [aw-1:0] rd_ptr;
  logic [aw:0] count;
  logic do_wr;
  logic do_rd;

  assign do_wr = wr_en && !full; // Writes to a full FIFO are lost
  assign do_rd = rd_en && !empty;

  always_ff @(posedge mac_clk) begin
    if (do_wr) mem[wr_ptr] <= wr_data;
  end

  always_ff @(posedge mac_clk) begin
    if (app_rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
    end else begin
      if (do_wr) wr_ptr <= wr_ptr + 1'b1; // Depth is a power of two
      if (do_rd) rd_ptr <= rd_ptr + 1'b1;
      case ({do_wr, do_rd})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  assign empty = (count == '0);
  assign full = (count == (aw + 1)'(depth));
  assign afull = (depth - int'(count)) <= afull_margin;

  if (first_word_fall_through) begin : g_fwft
    assign rd_data = mem[rd_ptr]; // Head visible while not empty
  end else begin : g_reg_read
    logic [width-1:0] rd_q;

    always_ff @(posedge mac_clk) begin
      if (do_rd) rd_q <= mem[rd_ptr];
    end

    assign rd_data = rd_q;
  end

  // Callers only pop what is there
  a_no_pop_empty: assert property (@(posedge mac_clk) disable iff (app_rst)
    rd_en |-> !empty);

endmodule

`default_nettype wire

// ==== rtl/tx_frame_if.sv ====
`timescale 1ns/10ps
`default_nettype none

interface tx_frame_if;
  import udp_tx_pkg::*;

  word_t word;             // Data FIFO output
  logic word_rd;           // Pop one payload word
  ip_addr_t dest_ip;
  udp_port_t dest_port;
  word_count_t word_count;
  logic frame_ready;       // Head entry valid and no overflow
  logic frame_done;        // Pops the head entry

  modport queue (
    output word, dest_ip, dest_port, word_count, frame_ready,
    input word_rd, frame_done
  );

  modport framer (
    input word, dest_ip, dest_port, word_count, frame_ready,
    output word_rd, frame_done
  );

  modport calc (input dest_ip, word_count);

endinterface

`default_nettype wire

// ==== rtl/udp_tx_pkg.sv ====
`default_nettype none

package udp_tx_pkg;

  typedef logic [63:0] word_t;
  typedef logic [7:0] byte_en_t;
  typedef logic [47:0] mac_addr_t;
  typedef logic [31:0] ip_addr_t;
  typedef logic [15:0] udp_port_t;
  typedef logic [15:0] word_count_t; // Payload words in one frame
  typedef logic [15:0] len16_t;
  typedef logic [7:0] arp_addr_t;

  localparam int data_fifo_depth = 256;
  localparam int ctrl_fifo_depth = 16;
  localparam int afull_margin = 8; // Free slots left when almost-full rises

  // Last word only carries the two trailing payload bytes
  localparam byte_en_t byte_en_last = 8'b00000011;

  typedef enum logic [3:0] {
    idle,
    hdr_eth_ucast,
    hdr_eth_mcast,
    hdr_eth_type,
    hdr_ip_len,
    hdr_ip_addr,
    hdr_udp,
    data_first,
    data,
    data_last
  } tx_state_e;

endpackage

`default_nettype wire

// ==== rtl/udp_proto_pkg.sv ====
`default_nettype none

package udp_proto_pkg;

  // Ethernet
  localparam logic [15:0] ethertype_ipv4 = 16'h0800;
  localparam logic [23:0] mcast_mac_prefix = 24'h01005e; // 01:00:5e
  localparam logic [3:0] mcast_ip_nibble = 4'b1110;     // Class D, 224.0.0.0/4

  // IPv4, 20-byte header with no options
  localparam logic [7:0] ip_ver_ihl = 8'h45;
  localparam logic [15:0] ip_flags_dont_frag = 16'h4000;
  localparam logic [7:0] ip_proto_udp = 8'd17;
  localparam logic [7:0] ip_ttl = 8'd1; // Stays on the local segment

  // Header sizes in bytes
  localparam logic [15:0] ip_udp_hdr_bytes = 16'd28;
  localparam logic [15:0] udp_hdr_bytes = 16'd8;

endpackage

`default_nettype wire
